/* design/exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module exec_top import rv_isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  rv_opcode_e            opcode_i,
  input  rv_alu_op_e            alu_op_i,
  input  rv_sys_op_e            sys_op_i,
  input  logic [`RV_CSR_AW-1:0] csr_addr_i,
  input  logic [4:0]            rd_i,
  input  logic [`RV_XLEN-1:0]   op1_i,
  input  logic [`RV_XLEN-1:0]   op2_i,
  input  logic [`RV_XLEN-1:0]   base_i,
  input  logic [`RV_XLEN-1:0]   imm_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [4:0]            rd_o,
  output logic                  rd_wen_o,
  output logic [`RV_XLEN-1:0]   rd_wdata_o,
  output logic [`RV_XLEN-1:0]   npc_o,
  output logic                  ebreak_o,
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output logic [`RV_XLEN-1:0]   wb_adr_o,
  output logic [`RV_XLEN-1:0]   wb_dat_o,
  output logic [`RV_XLEN/8-1:0] wb_sel_o,
  input  logic                  wb_ack_i,
  input  logic [`RV_XLEN-1:0]   wb_dat_i
);

  logic                  mem_req;
  logic                  mem_we;
  logic [`RV_XLEN-1:0]   mem_addr;
  logic [`RV_XLEN-1:0]   mem_wdata;
  logic                  mem_done;
  logic [`RV_XLEN-1:0]   mem_rdata;
  logic [`RV_XLEN-1:0]   alu_a;
  logic [`RV_XLEN-1:0]   alu_b;
  rv_alu_op_e            alu_op;
  logic [`RV_XLEN-1:0]   alu_res;
  logic                  csr_wen;
  logic [`RV_CSR_AW-1:0] csr_waddr;
  logic [`RV_XLEN-1:0]   csr_wdata;
  logic [`RV_CSR_AW-1:0] csr_raddr;
  logic [`RV_XLEN-1:0]   csr_rdata;
  logic                  csr_ecall;
  logic [`RV_XLEN-1:0]   csr_epc;
  logic                  csr_mret;
  logic [`RV_XLEN-1:0]   mtvec;
  logic [`RV_XLEN-1:0]   mepc;

  rv_exu u_exu (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .opcode_i    (opcode_i),
    .alu_op_i    (alu_op_i),
    .sys_op_i    (sys_op_i),
    .csr_addr_i  (csr_addr_i),
    .rd_i        (rd_i),
    .op1_i       (op1_i),
    .op2_i       (op2_i),
    .base_i      (base_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wen_o    (rd_wen_o),
    .rd_wdata_o  (rd_wdata_o),
    .npc_o       (npc_o),
    .ebreak_o    (ebreak_o),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_done_i  (mem_done),
    .mem_rdata_i (mem_rdata),
    .alu_a_o     (alu_a),
    .alu_b_o     (alu_b),
    .alu_op_o    (alu_op),
    .alu_res_i   (alu_res),
    .csr_wen_o   (csr_wen),
    .csr_waddr_o (csr_waddr),
    .csr_wdata_o (csr_wdata),
    .csr_raddr_o (csr_raddr),
    .csr_rdata_i (csr_rdata),
    .csr_ecall_o (csr_ecall),
    .csr_epc_o   (csr_epc),
    .csr_mret_o  (csr_mret),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc)
  );

  rv_alu u_alu (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .op_i  (alu_op),
    .res_o (alu_res)
  );

  rv_csr_file u_csr (
    .clk     (clk),
    .rst     (rst),
    .wen_i   (csr_wen),
    .waddr_i (csr_waddr),
    .wdata_i (csr_wdata),
    .raddr_i (csr_raddr),
    .rdata_o (csr_rdata),
    .ecall_i (csr_ecall),
    .epc_i   (csr_epc),
    .mret_i  (csr_mret),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  rv_lsu_wb u_lsu (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .done_o   (mem_done),
    .rdata_o  (mem_rdata),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o),
    .wb_ack_i (wb_ack_i),
    .wb_dat_i (wb_dat_i)
  );

endmodule

`default_nettype wire

/* design/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_alu import rv_isa_pkg::*; (
  input  logic [`RV_XLEN-1:0] a_i,
  input  logic [`RV_XLEN-1:0] b_i,
  input  rv_alu_op_e          op_i,
  output logic [`RV_XLEN-1:0] res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;

  always_comb begin
    res_o = '0;
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;  // zero means equal for branches
      ALU_AND:  res_o = a_i & b_i;
      ALU_OR:   res_o = a_i | b_i;
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      ALU_SLT:  res_o = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_SGE:  res_o = {{(`RV_XLEN-1){1'b0}}, ~lt_s};
      ALU_SGEU: res_o = {{(`RV_XLEN-1){1'b0}}, ~lt_u};
      default:  res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* design/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// csr address field
`define RV_CSR_AW 12

// machine trap vector after reset
`define RV_MTVEC_RESET 32'h0000_0100

// mpp = machine, interrupts off
`define RV_MSTATUS_RESET 32'h0000_1800

`endif

/* design/rv_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_csr_file import rv_isa_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wen_i,
  input  logic [`RV_CSR_AW-1:0]  waddr_i,
  input  logic [`RV_XLEN-1:0]    wdata_i,
  input  logic [`RV_CSR_AW-1:0]  raddr_i,
  output logic [`RV_XLEN-1:0]    rdata_o,
  input  logic                   ecall_i,
  input  logic [`RV_XLEN-1:0]    epc_i,
  input  logic                   mret_i,
  output logic [`RV_XLEN-1:0]    mtvec_o,
  output logic [`RV_XLEN-1:0]    mepc_o
);

  logic [`RV_XLEN-1:0] mstatus_q;
  logic [`RV_XLEN-1:0] mtvec_q;
  logic [`RV_XLEN-1:0] mepc_q;
  logic [`RV_XLEN-1:0] mcause_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= `RV_MSTATUS_RESET;
      mtvec_q   <= `RV_MTVEC_RESET;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (wen_i) begin
        case (waddr_i)
          CSR_MSTATUS: mstatus_q <= wdata_i;
          CSR_MTVEC:   mtvec_q   <= wdata_i;
          CSR_MEPC:    mepc_q    <= wdata_i;
          CSR_MCAUSE:  mcause_q  <= wdata_i;
          default:     mcause_q  <= mcause_q;  // unknown address, dropped
        endcase
      end
      if (ecall_i) begin
        mepc_q   <= epc_i;
        mcause_q <= 'd11;  // ecall from m-mode
      end
      if (mret_i) begin
        mstatus_q[3] <= mstatus_q[7];  // mie <= mpie
        mstatus_q[7] <= 1'b1;
      end
    end
  end

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

endmodule

`default_nettype wire

/* design/rv_exu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_exu import rv_isa_pkg::*, rv_exu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  rv_opcode_e            opcode_i,
  input  rv_alu_op_e            alu_op_i,
  input  rv_sys_op_e            sys_op_i,
  input  logic [`RV_CSR_AW-1:0] csr_addr_i,
  input  logic [4:0]            rd_i,
  input  logic [`RV_XLEN-1:0]   op1_i,
  input  logic [`RV_XLEN-1:0]   op2_i,
  input  logic [`RV_XLEN-1:0]   base_i,
  input  logic [`RV_XLEN-1:0]   imm_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic [4:0]            rd_o,
  output logic                  rd_wen_o,
  output logic [`RV_XLEN-1:0]   rd_wdata_o,
  output logic [`RV_XLEN-1:0]   npc_o,
  output logic                  ebreak_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output logic [`RV_XLEN-1:0]   mem_addr_o,
  output logic [`RV_XLEN-1:0]   mem_wdata_o,
  input  logic                  mem_done_i,
  input  logic [`RV_XLEN-1:0]   mem_rdata_i,
  output logic [`RV_XLEN-1:0]   alu_a_o,
  output logic [`RV_XLEN-1:0]   alu_b_o,
  output rv_alu_op_e            alu_op_o,
  input  logic [`RV_XLEN-1:0]   alu_res_i,
  output logic                  csr_wen_o,
  output logic [`RV_CSR_AW-1:0] csr_waddr_o,
  output logic [`RV_XLEN-1:0]   csr_wdata_o,
  output logic [`RV_CSR_AW-1:0] csr_raddr_o,
  input  logic [`RV_XLEN-1:0]   csr_rdata_i,
  output logic                  csr_ecall_o,
  output logic [`RV_XLEN-1:0]   csr_epc_o,
  output logic                  csr_mret_o,
  input  logic [`RV_XLEN-1:0]   mtvec_i,
  input  logic [`RV_XLEN-1:0]   mepc_i
);

  exu_state_e            state_q;
  rv_opcode_e            opcode_q;
  rv_alu_op_e            alu_op_q;
  rv_sys_op_e            sys_op_q;
  logic [`RV_CSR_AW-1:0] csr_addr_q;
  logic [4:0]            rd_q;
  logic [`RV_XLEN-1:0]   op1_q;
  logic [`RV_XLEN-1:0]   op2_q;
  logic [`RV_XLEN-1:0]   target_q;
  logic [`RV_XLEN-1:0]   pc_q;
  logic [`RV_XLEN-1:0]   target_d;
  logic [`RV_XLEN-1:0]   pc_plus4;
  logic                  in_fire;
  logic                  out_fire;
  logic                  is_mem_d;
  logic                  is_csr_op;
  logic                  taken;

  assign in_ready_o = (state_q == EXU_IDLE);
  assign in_fire    = in_valid_i && in_ready_o;
  assign is_mem_d   = (opcode_i == OPC_LOAD) || (opcode_i == OPC_STORE);
  assign target_d   = base_i + imm_i;

  // request straight from the accept edge
  assign mem_req_o   = in_fire && is_mem_d;
  assign mem_we_o    = (opcode_i == OPC_STORE);
  assign mem_addr_o  = target_d;
  assign mem_wdata_o = op2_i;

  assign out_valid_o = (state_q == EXU_DONE) || ((state_q == EXU_MEM) && mem_done_i);
  assign out_fire    = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= EXU_IDLE;
    end else begin
      case (state_q)
        EXU_IDLE: if (in_fire) state_q <= is_mem_d ? EXU_MEM : EXU_DONE;
        EXU_MEM:  if (out_fire) state_q <= EXU_IDLE;
                  else if (mem_done_i) state_q <= EXU_DONE;  // load data stays in the lsu
        EXU_DONE: if (out_fire) state_q <= EXU_IDLE;
        default:  state_q <= EXU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      opcode_q   <= opcode_i;
      alu_op_q   <= alu_op_i;
      sys_op_q   <= sys_op_i;
      csr_addr_q <= csr_addr_i;
      rd_q       <= rd_i;
      op1_q      <= op1_i;
      op2_q      <= op2_i;
      target_q   <= target_d;
      pc_q       <= pc_i;
    end
  end

  assign alu_a_o  = op1_q;
  assign alu_b_o  = op2_q;
  assign alu_op_o = alu_op_q;
  assign pc_plus4 = pc_q + 'd4;
  assign taken    = (alu_op_q == ALU_SUB) ? (alu_res_i == '0) : (alu_res_i != '0);

  assign is_csr_op = (opcode_q == OPC_SYSTEM) &&
                     ((sys_op_q == SYS_CSRRW) || (sys_op_q == SYS_CSRRS) ||
                      (sys_op_q == SYS_CSRRC));

  // side effects land only on the output transfer
  assign csr_raddr_o = csr_addr_q;
  assign csr_waddr_o = csr_addr_q;
  assign csr_wen_o   = out_fire && is_csr_op;
  assign csr_ecall_o = out_fire && (opcode_q == OPC_SYSTEM) && (sys_op_q == SYS_ECALL);
  assign csr_mret_o  = out_fire && (opcode_q == OPC_SYSTEM) && (sys_op_q == SYS_MRET);
  assign csr_epc_o   = pc_q;

  always_comb begin
    case (sys_op_q)
      SYS_CSRRS: csr_wdata_o = csr_rdata_i | op1_q;
      SYS_CSRRC: csr_wdata_o = csr_rdata_i & ~op1_q;
      default:   csr_wdata_o = op1_q;
    endcase
  end

  always_comb begin
    npc_o      = pc_plus4;
    rd_wdata_o = '0;
    case (opcode_q)
      OPC_ALU:    rd_wdata_o = alu_res_i;
      OPC_LOAD:   rd_wdata_o = mem_rdata_i;
      OPC_BRANCH: npc_o = taken ? target_q : pc_plus4;
      OPC_JUMP: begin
        rd_wdata_o = pc_plus4;  // link
        npc_o      = target_q;
      end
      OPC_SYSTEM: begin
        rd_wdata_o = csr_rdata_i;  // old csr value
        if (sys_op_q == SYS_ECALL) npc_o = mtvec_i;
        else if (sys_op_q == SYS_MRET) npc_o = mepc_i;
      end
      default:    npc_o = pc_plus4;
    endcase
  end

  assign rd_o     = rd_q;
  assign rd_wen_o = (rd_q != 5'd0) &&
                    ((opcode_q == OPC_ALU) || (opcode_q == OPC_LOAD) ||
                     (opcode_q == OPC_JUMP) || is_csr_op);
  assign ebreak_o = (opcode_q == OPC_SYSTEM) && (sys_op_q == SYS_EBREAK);

endmodule

`default_nettype wire

/* design/rv_exu_pkg.sv */
`default_nettype none

package rv_exu_pkg;

  typedef enum logic [1:0] {
    EXU_IDLE,  // waiting for decode
    EXU_MEM,   // load/store on the bus
    EXU_DONE   // result held for writeback
  } exu_state_e;

  typedef enum logic {
    LSU_IDLE,
    LSU_BUS
  } lsu_state_e;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
`default_nettype none

`include "rv_config.svh"

package rv_isa_pkg;

  typedef enum logic [2:0] {
    OPC_ALU,
    OPC_LOAD,
    OPC_STORE,
    OPC_BRANCH,
    OPC_JUMP,
    OPC_SYSTEM
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_SGE,
    ALU_SGEU
  } rv_alu_op_e;

  typedef enum logic [2:0] {
    SYS_CSRRW,
    SYS_CSRRS,
    SYS_CSRRC,
    SYS_ECALL,
    SYS_MRET,
    SYS_EBREAK
  } rv_sys_op_e;

  localparam logic [`RV_CSR_AW-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [`RV_CSR_AW-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [`RV_CSR_AW-1:0] CSR_MEPC    = 12'h341;
  localparam logic [`RV_CSR_AW-1:0] CSR_MCAUSE  = 12'h342;

endpackage

`default_nettype wire

/* design/rv_lsu_wb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module rv_lsu_wb import rv_exu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`RV_XLEN-1:0]     addr_i,
  input  logic [`RV_XLEN-1:0]     wdata_i,
  output logic                    done_o,
  output logic [`RV_XLEN-1:0]     rdata_o,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [`RV_XLEN-1:0]     wb_adr_o,
  output logic [`RV_XLEN-1:0]     wb_dat_o,
  output logic [`RV_XLEN/8-1:0]   wb_sel_o,
  input  logic                    wb_ack_i,
  input  logic [`RV_XLEN-1:0]     wb_dat_i
);

  lsu_state_e state_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= LSU_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= (state_q == LSU_BUS) && wb_ack_i;  // one-cycle pulse
      case (state_q)
        LSU_IDLE: if (req_i) state_q <= LSU_BUS;
        LSU_BUS:  if (wb_ack_i) state_q <= LSU_IDLE;
        default:  state_q <= LSU_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == LSU_IDLE) && req_i) begin
      wb_we_o  <= we_i;
      wb_adr_o <= addr_i;
      wb_dat_o <= wdata_i;
    end
    if ((state_q == LSU_BUS) && wb_ack_i) begin
      rdata_o <= wb_dat_i;  // held until next request
    end
  end

  assign wb_cyc_o = (state_q == LSU_BUS);
  assign wb_stb_o = (state_q == LSU_BUS);
  assign wb_sel_o = '1;  // word accesses only

endmodule

`default_nettype wire

/* dv/exec_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module exec_assert (
  input logic                clk,
  input logic                rst,
  input logic                wb_cyc_o,
  input logic                wb_stb_o,
  input logic                wb_ack_i,
  input logic                in_ready_o,
  input logic                out_valid_o,
  input logic                out_ready_i,
  input logic [4:0]          rd_o,
  input logic                rd_wen_o,
  input logic [`RV_XLEN-1:0] rd_wdata_o,
  input logic [`RV_XLEN-1:0] npc_o,
  input logic                ebreak_o
);

  int fail_cnt = 0;

  // classic cycle stays up until the slave acks
  a_cycle_held: assert property (@(posedge clk) disable iff (rst)
    (wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o))
    else begin
      $error("wb_stb_o or wb_cyc_o dropped before ack");
      fail_cnt = fail_cnt + 1;
    end

  a_cycle_ends: assert property (@(posedge clk) disable iff (rst)
    (wb_cyc_o && wb_ack_i) |=> !wb_cyc_o)
    else begin
      $error("wb_cyc_o still high after ack");
      fail_cnt = fail_cnt + 1;
    end

  a_ready_after_transfer: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && out_ready_i) |=> (in_ready_o && !out_valid_o))
    else begin
      $error("in_ready_o not back the cycle after the output transfer");
      fail_cnt = fail_cnt + 1;
    end

  // result must hold while writeback stalls
  a_hold_under_stall: assert property (@(posedge clk) disable iff (rst)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(rd_o) && $stable(rd_wen_o) &&
      $stable(rd_wdata_o) && $stable(npc_o) && $stable(ebreak_o)))
    else begin
      $error("result outputs changed under back-pressure");
      fail_cnt = fail_cnt + 1;
    end

  a_idle_bus_after_reset: assert property (@(posedge clk) rst |=> !wb_cyc_o)
    else begin
      $error("wb_cyc_o high right after reset");
      fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

/* dv/exec_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module exec_checker import rv_isa_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid_i,
  input  logic                  in_ready_i,
  input  rv_opcode_e            opcode_i,
  input  rv_alu_op_e            alu_op_i,
  input  rv_sys_op_e            sys_op_i,
  input  logic [`RV_CSR_AW-1:0] csr_addr_i,
  input  logic [4:0]            in_rd_i,
  input  logic [`RV_XLEN-1:0]   op1_i,
  input  logic [`RV_XLEN-1:0]   op2_i,
  input  logic [`RV_XLEN-1:0]   base_i,
  input  logic [`RV_XLEN-1:0]   imm_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic                  out_valid_i,
  input  logic                  out_ready_i,
  input  logic [4:0]            out_rd_i,
  input  logic                  rd_wen_i,
  input  logic [`RV_XLEN-1:0]   rd_wdata_i,
  input  logic [`RV_XLEN-1:0]   npc_i,
  input  logic                  ebreak_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic [`RV_XLEN/8-1:0] wb_sel_i,
  output int                    err_cnt_o,
  output int                    in_cnt_o,
  output int                    out_cnt_o
);

  typedef struct packed {
    rv_opcode_e            opc;
    rv_alu_op_e            aop;
    rv_sys_op_e            sop;
    logic [`RV_CSR_AW-1:0] csr;
    logic [4:0]            rd;
    logic [`RV_XLEN-1:0]   op1;
    logic [`RV_XLEN-1:0]   op2;
    logic [`RV_XLEN-1:0]   base;
    logic [`RV_XLEN-1:0]   imm;
    logic [`RV_XLEN-1:0]   pc;
  } instr_t;

  instr_t              pending[$];
  logic [`RV_XLEN-1:0] sh_mstatus;
  logic [`RV_XLEN-1:0] sh_mtvec;
  logic [`RV_XLEN-1:0] sh_mepc;
  logic [`RV_XLEN-1:0] sh_mcause;
  logic [`RV_XLEN-1:0] sh_mem [0:63];

  function automatic logic [`RV_XLEN-1:0] alu_ref(input rv_alu_op_e op,
                                                  input logic [`RV_XLEN-1:0] a,
                                                  input logic [`RV_XLEN-1:0] b);
    logic lt;
    logic ltu;
    lt  = $signed(a) < $signed(b);
    ltu = a < b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_SLT:  return lt ? 32'd1 : 32'd0;
      ALU_SLTU: return ltu ? 32'd1 : 32'd0;
      ALU_SGE:  return lt ? 32'd0 : 32'd1;
      ALU_SGEU: return ltu ? 32'd0 : 32'd1;
      default:  return 32'd0;
    endcase
  endfunction

  function automatic logic [`RV_XLEN-1:0] csr_read(input logic [`RV_CSR_AW-1:0] a);
    case (a)
      CSR_MSTATUS: return sh_mstatus;
      CSR_MTVEC:   return sh_mtvec;
      CSR_MEPC:    return sh_mepc;
      CSR_MCAUSE:  return sh_mcause;
      default:     return 32'd0;  // unknown csr
    endcase
  endfunction

  function automatic string class_name(input rv_opcode_e opc);
    case (opc)
      OPC_ALU:    return "alu";
      OPC_LOAD:   return "load";
      OPC_STORE:  return "store";
      OPC_BRANCH: return "branch";
      OPC_JUMP:   return "jump";
      default:    return "system";
    endcase
  endfunction

  // expected writeback fields from shadow state
  function automatic void ref_model(input instr_t t, output logic wen,
                                    output logic [`RV_XLEN-1:0] wdata,
                                    output logic [`RV_XLEN-1:0] npc, output logic ebrk);
    logic [`RV_XLEN-1:0] r;
    logic [`RV_XLEN-1:0] ea;
    wen   = 1'b0;
    wdata = '0;
    npc   = t.pc + 32'd4;
    ebrk  = 1'b0;
    r     = alu_ref(t.aop, t.op1, t.op2);
    ea    = t.base + t.imm;
    case (t.opc)
      OPC_ALU: begin
        wen   = 1'b1;
        wdata = r;
      end
      OPC_LOAD: begin
        wen   = 1'b1;
        wdata = sh_mem[ea[7:2]];
      end
      OPC_BRANCH: begin
        if ((t.aop == ALU_SUB) ? (r == 32'd0) : (r != 32'd0)) npc = ea;
      end
      OPC_JUMP: begin
        wen   = 1'b1;
        wdata = t.pc + 32'd4;
        npc   = ea;
      end
      OPC_SYSTEM: begin
        case (t.sop)
          SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
            wen   = 1'b1;
            wdata = csr_read(t.csr);
          end
          SYS_ECALL:  npc = sh_mtvec;
          SYS_MRET:   npc = sh_mepc;
          SYS_EBREAK: ebrk = 1'b1;
          default:    npc = t.pc + 32'd4;
        endcase
      end
      default: wen = 1'b0;
    endcase
    if (t.rd == 5'd0) wen = 1'b0;
  endfunction

  function automatic void commit(input instr_t t);
    logic [`RV_XLEN-1:0] old;
    logic [`RV_XLEN-1:0] nv;
    logic [`RV_XLEN-1:0] ea;
    ea  = t.base + t.imm;
    old = csr_read(t.csr);
    nv  = t.op1;
    if (t.sop == SYS_CSRRS) nv = old | t.op1;
    if (t.sop == SYS_CSRRC) nv = old & ~t.op1;
    if (t.opc == OPC_STORE) sh_mem[ea[7:2]] = t.op2;
    if (t.opc == OPC_SYSTEM) begin
      case (t.sop)
        SYS_CSRRW, SYS_CSRRS, SYS_CSRRC: begin
          case (t.csr)
            CSR_MSTATUS: sh_mstatus = nv;
            CSR_MTVEC:   sh_mtvec   = nv;
            CSR_MEPC:    sh_mepc    = nv;
            CSR_MCAUSE:  sh_mcause  = nv;
            default:     sh_mcause  = sh_mcause;
          endcase
        end
        SYS_ECALL: begin
          sh_mepc   = t.pc;
          sh_mcause = 32'd11;
        end
        SYS_MRET: begin
          sh_mstatus[3] = sh_mstatus[7];
          sh_mstatus[7] = 1'b1;
        end
        default: sh_mcause = sh_mcause;
      endcase
    end
  endfunction

  task automatic check_field(input string name, input logic [`RV_XLEN-1:0] exp,
                             input logic [`RV_XLEN-1:0] act);
    if (exp !== act) begin
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
      err_cnt_o = err_cnt_o + 1;
    end
  endtask

  initial begin
    err_cnt_o  = 0;
    in_cnt_o   = 0;
    out_cnt_o  = 0;
    sh_mstatus = `RV_MSTATUS_RESET;
    sh_mtvec   = `RV_MTVEC_RESET;
    sh_mepc    = '0;
    sh_mcause  = '0;
    for (int i = 0; i < 64; i++) sh_mem[i] = '0;
  end

  always @(posedge clk) begin
    instr_t              t;
    logic                e_wen;
    logic [`RV_XLEN-1:0] e_wdata;
    logic [`RV_XLEN-1:0] e_npc;
    logic                e_ebrk;
    string               nm;
    if (!rst) begin
      if (in_valid_i && in_ready_i) begin
        t = '{opcode_i, alu_op_i, sys_op_i, csr_addr_i, in_rd_i, op1_i, op2_i, base_i,
              imm_i, pc_i};
        pending.push_back(t);
        in_cnt_o = in_cnt_o + 1;
      end else if (out_valid_i && pending.size() == 0) begin
        $display("Result presented with no accepted instruction in flight");
        err_cnt_o = err_cnt_o + 1;
      end else if (out_valid_i && out_ready_i) begin
        t = pending.pop_front();
        out_cnt_o = out_cnt_o + 1;
        ref_model(t, e_wen, e_wdata, e_npc, e_ebrk);
        nm = class_name(t.opc);
        check_field({nm, ".rd"}, {27'd0, t.rd}, {27'd0, out_rd_i});
        check_field({nm, ".rd_wen"}, {31'd0, e_wen}, {31'd0, rd_wen_i});
        if (e_wen) check_field({nm, ".rd_wdata"}, e_wdata, rd_wdata_i);
        check_field({nm, ".npc"}, e_npc, npc_i);
        check_field({nm, ".ebreak"}, {31'd0, e_ebrk}, {31'd0, ebreak_i});
        commit(t);
      end
      if (wb_cyc_i && wb_stb_i) begin
        check_field("bus.sel", 32'h0000_000f, 32'(wb_sel_i));  // all four byte lanes
      end
    end
  end

endmodule

`default_nettype wire

/* dv/exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module exec_tb import rv_isa_pkg::*; ();

  localparam int NUM_ITEMS = 300;
  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 2000;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic                  in_ready;
  rv_opcode_e            opcode;
  rv_alu_op_e            alu_op;
  rv_sys_op_e            sys_op;
  logic [`RV_CSR_AW-1:0] csr_addr;
  logic [4:0]            rd;
  logic [`RV_XLEN-1:0]   op1;
  logic [`RV_XLEN-1:0]   op2;
  logic [`RV_XLEN-1:0]   base;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   pc;
  logic                  out_valid;
  logic                  out_ready;
  logic [4:0]            rd_out;
  logic                  rd_wen;
  logic [`RV_XLEN-1:0]   rd_wdata;
  logic [`RV_XLEN-1:0]   npc;
  logic                  ebreak;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`RV_XLEN-1:0]   wb_adr;
  logic [`RV_XLEN-1:0]   wb_dat_o;
  logic [`RV_XLEN/8-1:0] wb_sel;
  logic                  wb_ack;
  logic [`RV_XLEN-1:0]   wb_dat_i;
  logic [`RV_XLEN-1:0]   mem [0:63];
  logic                  mem_busy;
  int                    ack_delay;
  integer                seed;
  int                    timeouts;
  int                    err_cnt;
  int                    in_cnt;
  int                    out_cnt;

  exec_top u_dut (
    .clk(clk), .rst(rst), .in_valid_i(in_valid), .in_ready_o(in_ready),
    .opcode_i(opcode), .alu_op_i(alu_op), .sys_op_i(sys_op), .csr_addr_i(csr_addr),
    .rd_i(rd), .op1_i(op1), .op2_i(op2), .base_i(base), .imm_i(imm), .pc_i(pc),
    .out_valid_o(out_valid), .out_ready_i(out_ready), .rd_o(rd_out), .rd_wen_o(rd_wen),
    .rd_wdata_o(rd_wdata), .npc_o(npc), .ebreak_o(ebreak), .wb_cyc_o(wb_cyc),
    .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_o),
    .wb_sel_o(wb_sel), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_i)
  );

  exec_checker u_checker (
    .clk(clk), .rst(rst), .in_valid_i(in_valid), .in_ready_i(in_ready),
    .opcode_i(opcode), .alu_op_i(alu_op), .sys_op_i(sys_op), .csr_addr_i(csr_addr),
    .in_rd_i(rd), .op1_i(op1), .op2_i(op2), .base_i(base), .imm_i(imm), .pc_i(pc),
    .out_valid_i(out_valid), .out_ready_i(out_ready), .out_rd_i(rd_out),
    .rd_wen_i(rd_wen), .rd_wdata_i(rd_wdata), .npc_i(npc), .ebreak_i(ebreak),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_sel_i(wb_sel),
    .err_cnt_o(err_cnt), .in_cnt_o(in_cnt), .out_cnt_o(out_cnt)
  );

  bind exec_top exec_assert u_assert (
    .clk(clk), .rst(rst), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_ack_i(wb_ack_i),
    .in_ready_o(in_ready_o), .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
    .rd_o(rd_o), .rd_wen_o(rd_wen_o), .rd_wdata_o(rd_wdata_o), .npc_o(npc_o),
    .ebreak_o(ebreak_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // writeback back-pressure
  always @(negedge clk) begin
    if (rst) out_ready = 1'b0;
    else out_ready = ($random(seed) % 4) != 0;
  end

  // wishbone slave, 0..3 cycles to ack
  always @(negedge clk) begin
    if (rst) begin
      wb_ack   = 1'b0;
      mem_busy = 1'b0;
    end else if (wb_ack) begin
      wb_ack   = 1'b0;
      mem_busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        ack_delay = $unsigned($random(seed)) % 4;
      end
      if (ack_delay == 0) begin
        wb_ack = 1'b1;
        if (wb_we) mem[wb_adr[7:2]] = wb_dat_o;
        else wb_dat_i = mem[wb_adr[7:2]];
      end else begin
        ack_delay = ack_delay - 1;
      end
    end
  end

  function automatic logic [`RV_CSR_AW-1:0] pick_csr(input int r);
    case (r % 5)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MEPC;
      3:       return CSR_MCAUSE;
      default: return 12'h7c0;  // not implemented
    endcase
  endfunction

  task automatic send(input rv_opcode_e o, input rv_alu_op_e a, input rv_sys_op_e s,
                      input logic [`RV_CSR_AW-1:0] c, input logic [4:0] d,
                      input logic [`RV_XLEN-1:0] x, input logic [`RV_XLEN-1:0] y,
                      input int waddr, input int widx);
    int n;
    n = 0;
    if (timeouts == 0) begin
      in_valid = 1'b1;
      opcode   = o;
      alu_op   = a;
      sys_op   = s;
      csr_addr = c;
      rd       = d;
      op1      = x;
      op2      = y;
      base     = waddr * 4;
      imm      = (widx - waddr) * 4;  // base+imm stays in the window
      pc       = {$random(seed)} & 32'hffff_fffc;
      while (!in_ready && n < ACCEPT_TIMEOUT) begin
        @(negedge clk);
        n = n + 1;
      end
      if (!in_ready) begin
        $display("Timed out waiting for in_ready_o");
        timeouts = timeouts + 1;
      end
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  initial begin
    int kind;
    int w;
    int n;
    seed      = 32'h612d14f2;
    timeouts  = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    opcode    = OPC_ALU;
    alu_op    = ALU_ADD;
    sys_op    = SYS_CSRRW;
    csr_addr  = '0;
    rd        = '0;
    op1       = '0;
    op2       = '0;
    base      = '0;
    imm       = '0;
    pc        = '0;
    out_ready = 1'b0;
    wb_ack    = 1'b0;
    wb_dat_i  = '0;
    mem_busy  = 1'b0;
    ack_delay = 0;
    for (int i = 0; i < 64; i++) mem[i] = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NUM_ITEMS; i++) begin
      kind = $unsigned($random(seed)) % 10;
      w    = $unsigned($random(seed)) % 64;
      case (kind)
        0, 1, 2: send(OPC_ALU, rv_alu_op_e'($unsigned($random(seed)) % 12), SYS_CSRRW, 0,
                      5'($random(seed)), $random(seed), $random(seed), 0, 0);
        3: send(OPC_BRANCH, rv_alu_op_e'($unsigned($random(seed)) % 12), SYS_CSRRW, 0,
                5'($random(seed)), $random(seed) % 4, $random(seed) % 4, w, i % 64);
        4: send(OPC_JUMP, ALU_ADD, SYS_CSRRW, 0, 5'($random(seed)), 0, 0, w, i % 64);
        5: begin
          send(OPC_STORE, ALU_ADD, SYS_CSRRW, 0, 5'd3, 0, $random(seed), i % 64, w);
          send(OPC_LOAD, ALU_ADD, SYS_CSRRW, 0, 5'($random(seed)), 0, 0, (i * 7) % 64, w);
        end
        6: send(OPC_LOAD, ALU_ADD, SYS_CSRRW, 0, 5'($random(seed)), 0, 0, i % 64, w);
        7: send(OPC_SYSTEM, ALU_ADD, rv_sys_op_e'($unsigned($random(seed)) % 3),
                pick_csr($unsigned($random(seed))), 5'($random(seed)), $random(seed), 0, 0, 0);
        8: begin
          send(OPC_SYSTEM, ALU_ADD, SYS_ECALL, 0, 5'd1, 0, 0, 0, 0);
          send(OPC_SYSTEM, ALU_ADD, SYS_CSRRS, CSR_MCAUSE, 5'd5, 0, 0, 0, 0);
          send(OPC_SYSTEM, ALU_ADD, SYS_MRET, 0, 5'd1, 0, 0, 0, 0);
          send(OPC_SYSTEM, ALU_ADD, SYS_CSRRS, CSR_MSTATUS, 5'd6, 0, 0, 0, 0);
        end
        default: send(OPC_SYSTEM, ALU_ADD, SYS_EBREAK, 0, 5'd2, 0, 0, 0, 0);
      endcase
    end
    n = 0;
    while (out_cnt != in_cnt && n < DRAIN_TIMEOUT && timeouts == 0) begin
      @(negedge clk);
      n = n + 1;
    end
    if (out_cnt != in_cnt) begin
      $display("Not every accepted instruction produced a result");
      timeouts = timeouts + 1;
    end
    $display("errors: mismatches %0d, assertions %0d, timeouts %0d, accepted %0d, results %0d",
             err_cnt, u_dut.u_assert.fail_cnt, timeouts, in_cnt, out_cnt);
    if (err_cnt == 0 && timeouts == 0 && u_dut.u_assert.fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module exec_tb -o exec_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/exec_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

/* tb.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_exu_pkg.sv
design/rv_alu.sv
design/rv_csr_file.sv
design/rv_exu.sv
design/rv_lsu_wb.sv
design/exec_top.sv
dv/exec_assert.sv
dv/exec_checker.sv
dv/exec_tb.sv
